//--- build.f
source/exu_pkg.sv
source/exu_control.sv
source/exu_alu.sv
source/exu_next_pc.sv
source/exu_writeback.sv
source/exu_execute.sv
tests/exu_execute_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
verilator --binary --timing --assert --top-module exu_execute_tb -f build.f -o exu_sim \
  > run.log 2>&1 &&
  ./obj_dir/exu_sim >> run.log 2>&1 ||
  echo "*** TEST FAILED ***" >> run.log
cat run.log
if grep -q "\*\*\* TEST FAILED \*\*\*" run.log; then
  exit 1
fi
exit 0

//--- tests/exu_execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_execute_tb;

  typedef struct packed {
    exu_pkg::exu_issue_t issue;
    logic                decode_valid;
    logic                block;
  } stim_entry_t;

  logic                 clock;
  logic                 reset;
  logic                 block;
  logic                 decode_valid;
  exu_pkg::exu_issue_t  issue;
  logic                 result_valid;
  exu_pkg::exu_result_t result;

  stim_entry_t          stim_table[$];
  exu_pkg::exu_result_t expected_result;
  logic                 expected_valid;
  logic                 have_state;
  integer               seed;
  int                   cycle_count;
  int                   timeout_limit;
  int                   current_entry;

  exu_execute exu_execute_inst (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .decode_valid (decode_valid),
    .issue        (issue),
    .result_valid (result_valid),
    .result       (result)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // Reference model

  function automatic logic [31:0] alu_reference(exu_pkg::alu_op_e op, logic [31:0] a,
                                                logic [31:0] b);
    logic [4:0]  s;
    logic        lt_s;
    logic        lt_u;
    logic [31:0] fill;
    s    = b[4:0];
    lt_u = a < b;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // Flipping the sign bit orders signed values
    fill = a[31] ? ~(32'hffff_ffff >> s) : 32'd0;
    case (op)
      exu_pkg::alu_add:                    alu_reference = a + b;
      exu_pkg::alu_sub:                    alu_reference = a + ~b + 32'd1;
      exu_pkg::alu_and:                    alu_reference = a & b;
      exu_pkg::alu_or:                     alu_reference = a | b;
      exu_pkg::alu_xor:                    alu_reference = a ^ b;
      exu_pkg::alu_sll:                    alu_reference = a << s;
      exu_pkg::alu_srl:                    alu_reference = a >> s;
      exu_pkg::alu_sra:                    alu_reference = (a >> s) | fill;
      exu_pkg::alu_slt, exu_pkg::alu_lt:   alu_reference = {31'd0, lt_s};
      exu_pkg::alu_sltu, exu_pkg::alu_ltu: alu_reference = {31'd0, lt_u};
      exu_pkg::alu_eq:                     alu_reference = {31'd0, a == b};
      exu_pkg::alu_ne:                     alu_reference = {31'd0, a != b};
      exu_pkg::alu_ge:                     alu_reference = {31'd0, ~lt_s};
      exu_pkg::alu_geu:                    alu_reference = {31'd0, ~lt_u};
      default:                             alu_reference = 32'd0;
    endcase
  endfunction

  function automatic exu_pkg::exu_result_t model_result(exu_pkg::exu_issue_t item);
    exu_pkg::exu_result_t r;
    logic [31:0]          b;
    logic [31:0]          seq_pc;
    logic [31:0]          target_pc;
    b = item.src2;
    if (item.operand2_sel == exu_pkg::op2_imm) b = item.imm;
    if (item.operand2_sel == exu_pkg::op2_csr) b = item.csr_src;
    seq_pc       = item.pc + 32'd4;
    target_pc    = item.pc + item.imm;
    r.alu_result = alu_reference(item.alu_op, item.src1, b);
    case (item.npc_sel)
      exu_pkg::npc_jal:    r.npc = target_pc;
      exu_pkg::npc_jalr:   r.npc = r.alu_result & 32'hffff_fffe;
      exu_pkg::npc_branch: r.npc = r.alu_result[0] ? target_pc : seq_pc;
      exu_pkg::npc_trap:   r.npc = item.csr_src;
      default:             r.npc = seq_pc;
    endcase
    case (item.wdata_sel)
      exu_pkg::wdata_snpc: r.rd_wdata = seq_pc;
      exu_pkg::wdata_dnpc: r.rd_wdata = target_pc;
      exu_pkg::wdata_csr:  r.rd_wdata = item.csr_src;
      default:             r.rd_wdata = r.alu_result;
    endcase
    r.csr_wdata1 = item.csr_cause_sel ? 32'd11 : r.alu_result;  // Machine ecall cause
    r.csr_wdata2 = item.csr_epc_sel ? item.pc : 32'd0;
    return r;
  endfunction

  ////////////////////
  // Stimulus helpers

  function automatic exu_pkg::exu_issue_t random_issue();
    exu_pkg::exu_issue_t item;
    item         = '0;
    item.pc      = $random(seed) & 32'hffff_fffc;
    item.imm     = $random(seed);
    item.src1    = $random(seed);
    item.src2    = $random(seed);
    item.csr_src = $random(seed);
    return item;
  endfunction

  task automatic add_entry(exu_pkg::exu_issue_t item, logic valid_in, logic block_in);
    stim_entry_t entry;
    entry.issue        = item;
    entry.decode_valid = valid_in;
    entry.block        = block_in;
    stim_table.push_back(entry);
  endtask

  task automatic compare_value(string what, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: entry %0d %s is %h, expected %h",
               $time, current_entry, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_stage();
    compare_value("result_valid", {31'd0, result_valid}, {31'd0, expected_valid});
    if (have_state) begin
      compare_value("alu_result", result.alu_result, expected_result.alu_result);
      compare_value("npc", result.npc, expected_result.npc);
      compare_value("rd_wdata", result.rd_wdata, expected_result.rd_wdata);
      compare_value("csr_wdata1", result.csr_wdata1, expected_result.csr_wdata1);
      compare_value("csr_wdata2", result.csr_wdata2, expected_result.csr_wdata2);
    end
  endtask

  initial begin
    exu_pkg::exu_issue_t item;
    stim_entry_t         entry;
    int                  i;
    int                  j;
    clock          = 1'b0;
    reset          = 1'b1;
    block          = 1'b0;
    decode_valid   = 1'b0;
    issue          = '0;
    seed           = 32'h50f908a9;
    cycle_count    = 0;
    current_entry  = -1;
    expected_valid = 1'b0;
    have_state     = 1'b0;

    item = random_issue();
    add_entry(item, 1'b0, 1'b0);  // Bubble right after reset
    for (i = 0; i < 16; i++) begin
      for (j = 0; j < 3; j++) begin
        item              = random_issue();
        item.alu_op       = exu_pkg::alu_op_e'(i[3:0]);
        item.operand2_sel = exu_pkg::operand2_sel_e'(j[1:0]);
        add_entry(item, 1'b1, 1'b0);
      end
    end
    item         = random_issue();
    item.npc_sel = exu_pkg::npc_jal;
    item.wdata_sel = exu_pkg::wdata_snpc;
    add_entry(item, 1'b1, 1'b0);
    for (j = 0; j < 2; j++) begin
      item              = random_issue();
      item.operand2_sel = exu_pkg::op2_imm;
      item.npc_sel      = exu_pkg::npc_jalr;
      item.wdata_sel    = exu_pkg::wdata_snpc;
      item.src1         = item.src1 & 32'hffff_fffe;
      item.imm          = (j == 0) ? (item.imm | 32'd1) : (item.imm & 32'hffff_fffe);
      add_entry(item, 1'b1, 1'b0);
    end
    for (i = 10; i < 16; i++) begin
      for (j = 0; j < 2; j++) begin
        item         = random_issue();
        item.alu_op  = exu_pkg::alu_op_e'(i[3:0]);
        item.npc_sel = exu_pkg::npc_branch;
        if (i < 12) begin
          item.src2 = (j == 0) ? item.src1 : item.src1 + 32'd1;
        end else begin
          item.src1 = (j == 0) ? 32'hffff_fff0 : 32'h0000_0010;  // Sign and magnitude disagree
          item.src2 = (j == 0) ? 32'h0000_0010 : 32'hffff_fff0;
        end
        add_entry(item, 1'b1, 1'b0);
      end
    end
    item               = random_issue();
    item.npc_sel       = exu_pkg::npc_trap;
    item.csr_cause_sel = 1'b1;
    item.csr_epc_sel   = 1'b1;
    add_entry(item, 1'b1, 1'b0);
    for (i = 1; i < 4; i++) begin
      for (j = 0; j < 4; j++) begin
        item               = random_issue();
        item.wdata_sel     = exu_pkg::wdata_sel_e'(i[1:0]);
        item.csr_cause_sel = j[0];
        item.csr_epc_sel   = j[1];
        add_entry(item, 1'b1, 1'b0);
      end
    end
    add_entry(random_issue(), 1'b1, 1'b0);
    for (i = 0; i < 4; i++) add_entry(random_issue(), i[0], 1'b1);  // Issue moves during the stall
    add_entry(random_issue(), 1'b0, 1'b0);
    for (i = 0; i < 3; i++) add_entry(random_issue(), 1'b1, 1'b1);
    add_entry(random_issue(), 1'b1, 1'b0);
    timeout_limit = stim_table.size() + 20;

    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_stage();
    for (i = 0; i < stim_table.size(); i++) begin
      entry         = stim_table[i];
      current_entry = i;
      issue         = entry.issue;
      decode_valid  = entry.decode_valid;
      block         = entry.block;
      @(posedge clock);
      if (!entry.block) begin
        expected_valid  = entry.decode_valid;
        expected_result = model_result(entry.issue);
        have_state      = 1'b1;
      end
      @(negedge clock);
      check_stage();
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/exu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module exu_execute (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   block,
  input  wire                   decode_valid,
  input  wire exu_pkg::exu_issue_t issue,
  output logic                  result_valid,
  output exu_pkg::exu_result_t  result
);

  exu_pkg::exu_state_t state;
  logic [31:0]         alu_result;
  logic [31:0]         npc;
  logic [31:0]         rd_wdata;
  logic [31:0]         csr_wdata1;
  logic [31:0]         csr_wdata2;

  exu_control exu_control_inst (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .decode_valid (decode_valid),
    .issue        (issue),
    .state        (state),
    .result_valid (result_valid)
  );

  exu_alu exu_alu_inst (
    .op       (state.alu_op),
    .operand1 (state.operand1),
    .operand2 (state.operand2),
    .result   (alu_result)
  );

  exu_next_pc exu_next_pc_inst (
    .state      (state),
    .alu_result (alu_result),
    .npc        (npc)
  );

  exu_writeback exu_writeback_inst (
    .state      (state),
    .alu_result (alu_result),
    .rd_wdata   (rd_wdata),
    .csr_wdata1 (csr_wdata1),
    .csr_wdata2 (csr_wdata2)
  );

  assign result = '{
    alu_result : alu_result,
    npc        : npc,
    rd_wdata   : rd_wdata,
    csr_wdata1 : csr_wdata1,
    csr_wdata2 : csr_wdata2
  };

endmodule

`default_nettype wire

//--- source/exu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exu_writeback (
  input  wire exu_pkg::exu_state_t state,
  input  wire [31:0]               alu_result,
  output logic [31:0]              rd_wdata,
  output logic [31:0]              csr_wdata1,
  output logic [31:0]              csr_wdata2
);

  ////////////////////
  // Register file

  always_comb begin
    case (state.wdata_sel)
      exu_pkg::wdata_alu:  rd_wdata = alu_result;
      exu_pkg::wdata_snpc: rd_wdata = state.snpc;
      exu_pkg::wdata_dnpc: rd_wdata = state.dnpc;
      exu_pkg::wdata_csr:  rd_wdata = state.csr_src;  // Old CSR value for csrrw and friends
      default:             rd_wdata = alu_result;
    endcase
  end

  ////////////////////
  // CSR file

  // Port 1 carries mcause on ecall, otherwise the new CSR value from the ALU
  assign csr_wdata1 = state.csr_cause_sel ? exu_pkg::ecall_cause : alu_result;

  assign csr_wdata2 = state.csr_epc_sel ? state.pc : 32'd0;  // mepc on ecall

endmodule

`default_nettype wire

//--- source/exu_next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module exu_next_pc (
  input  wire exu_pkg::exu_state_t state,
  input  wire [31:0]               alu_result,
  output logic [31:0]              npc
);

  logic        branch_taken;
  logic [31:0] jalr_target;

  assign branch_taken = alu_result[0];
  assign jalr_target  = {alu_result[31:1], 1'b0};  // rs1 + imm with the low bit dropped

  always_comb begin
    case (state.npc_sel)
      exu_pkg::npc_seq:    npc = state.snpc;
      exu_pkg::npc_jal:    npc = state.dnpc;
      exu_pkg::npc_jalr:   npc = jalr_target;
      exu_pkg::npc_branch: npc = branch_taken ? state.dnpc : state.snpc;
      exu_pkg::npc_trap:   npc = state.csr_src;  // mtvec or mepc from the CSR file
      default:             npc = state.snpc;
    endcase
  end

  ////////////////////
  // Checks

  // An indirect jump never lands on an odd address
  always_comb begin
    if (state.npc_sel == exu_pkg::npc_jalr) begin
      jalr_aligned : assert final (npc[0] == 1'b0);
    end
  end

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  wire exu_pkg::alu_op_e op,
  input  wire [31:0]            operand1,
  input  wire [31:0]            operand2,
  output logic [31:0]           result
);

  logic [4:0]  shamt;
  logic        equal;
  logic        less_signed;
  logic        less_unsigned;
  logic [31:0] sum;
  logic [31:0] difference;

  assign shamt         = operand2[4:0];  // RV32 shifts ignore the upper bits
  assign sum           = operand1 + operand2;
  assign difference    = operand1 - operand2;
  assign equal         = (operand1 == operand2);
  assign less_signed   = ($signed(operand1) < $signed(operand2));
  assign less_unsigned = (operand1 < operand2);

  ////////////////////
  // Operation select

  always_comb begin
    result = 32'd0;
    case (op)
      exu_pkg::alu_add:  result = sum;
      exu_pkg::alu_sub:  result = difference;
      exu_pkg::alu_and:  result = operand1 & operand2;
      exu_pkg::alu_or:   result = operand1 | operand2;
      exu_pkg::alu_xor:  result = operand1 ^ operand2;
      exu_pkg::alu_sll:  result = operand1 << shamt;
      exu_pkg::alu_srl:  result = operand1 >> shamt;
      exu_pkg::alu_sra:  result = $unsigned($signed(operand1) >>> shamt);
      exu_pkg::alu_slt:  result = {31'd0, less_signed};
      exu_pkg::alu_sltu: result = {31'd0, less_unsigned};

      // Branch compares set only bit 0, which decides the branch downstream
      exu_pkg::alu_eq:   result = {31'd0, equal};
      exu_pkg::alu_ne:   result = {31'd0, !equal};
      exu_pkg::alu_lt:   result = {31'd0, less_signed};
      exu_pkg::alu_ge:   result = {31'd0, !less_signed};
      exu_pkg::alu_ltu:  result = {31'd0, less_unsigned};
      exu_pkg::alu_geu:  result = {31'd0, !less_unsigned};
      default:           result = sum;
    endcase
  end

endmodule

`default_nettype wire

//--- source/exu_control.sv
`timescale 1ns/1ps
`default_nettype none

module exu_control (
  input  wire                  clock,
  input  wire                  reset,
  input  wire                  block,
  input  wire                  decode_valid,
  input  wire exu_pkg::exu_issue_t issue,
  output exu_pkg::exu_state_t  state,
  output logic                 result_valid
);

  logic [31:0] operand2_next;

  ////////////////////
  // Operand 2 select

  always_comb begin
    case (issue.operand2_sel)
      exu_pkg::op2_imm: operand2_next = issue.imm;
      exu_pkg::op2_csr: operand2_next = issue.csr_src;  // CSR read value for csrrs and csrrc
      default:          operand2_next = issue.src2;
    endcase
  end

  ////////////////////
  // Pipeline register

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (!block) begin
      result_valid <= decode_valid;  // A bubble clears the flag
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      state.alu_op        <= issue.alu_op;
      state.operand1      <= issue.src1;
      state.operand2      <= operand2_next;
      state.pc            <= issue.pc;
      state.snpc          <= issue.pc + 32'd4;
      state.dnpc          <= issue.pc + issue.imm;  // Shared by jal, branch and auipc
      state.csr_src       <= issue.csr_src;
      state.npc_sel       <= issue.npc_sel;
      state.wdata_sel     <= issue.wdata_sel;
      state.csr_cause_sel <= issue.csr_cause_sel;
      state.csr_epc_sel   <= issue.csr_epc_sel;
    end
  end

  ////////////////////
  // Checks

  // Reset leaves no instruction in flight
  reset_clears_valid : assert property (
    @(posedge clock) reset |=> !result_valid
  );

  // A stall holds the whole stage, so the result outputs cannot move either
  block_holds_stage : assert property (
    @(posedge clock) disable iff (reset)
    block |=> ($stable(state) && $stable(result_valid))
  );

endmodule

`default_nettype wire

//--- source/exu_pkg.sv
`default_nettype none

package exu_pkg;

  ////////////////////
  // Select codes

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,  // Compare codes below drive the branch decision
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13,
    alu_ltu  = 4'd14,
    alu_geu  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    op2_src2 = 2'd0,
    op2_imm  = 2'd1,
    op2_csr  = 2'd2
  } operand2_sel_e;

  typedef enum logic [2:0] {
    npc_seq    = 3'd0,
    npc_jal    = 3'd1,
    npc_jalr   = 3'd2,
    npc_branch = 3'd3,
    npc_trap   = 3'd4  // Covers ecall and mret with the target on csr_src
  } npc_sel_e;

  typedef enum logic [1:0] {
    wdata_alu  = 2'd0,
    wdata_snpc = 2'd1,  // Link address for jal and jalr
    wdata_dnpc = 2'd2,  // Used by auipc
    wdata_csr  = 2'd3
  } wdata_sel_e;

  localparam logic [31:0] ecall_cause = 32'd11;  // Environment call from M mode

  ////////////////////
  // Stage records

  typedef struct packed {
    logic [31:0]   pc;
    logic [31:0]   imm;
    logic [31:0]   src1;
    logic [31:0]   src2;
    logic [31:0]   csr_src;
    alu_op_e       alu_op;
    operand2_sel_e operand2_sel;
    npc_sel_e      npc_sel;
    wdata_sel_e    wdata_sel;
    logic          csr_cause_sel;
    logic          csr_epc_sel;
  } exu_issue_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [31:0] operand1;
    logic [31:0] operand2;
    logic [31:0] pc;
    logic [31:0] snpc;
    logic [31:0] dnpc;
    logic [31:0] csr_src;
    npc_sel_e    npc_sel;
    wdata_sel_e  wdata_sel;
    logic        csr_cause_sel;
    logic        csr_epc_sel;
  } exu_state_t;

  typedef struct packed {
    logic [31:0] alu_result;
    logic [31:0] npc;
    logic [31:0] rd_wdata;
    logic [31:0] csr_wdata1;
    logic [31:0] csr_wdata2;
  } exu_result_t;

endpackage

`default_nettype wire
